// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LUI,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_ILLEGAL
    } inst_class_e;

endpackage

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     native_rstn,
    input  wire                     we,
    input  wire cpu_pkg::reg_addr_t waddr,
    input  wire cpu_pkg::word_t     wdata,
    input  wire cpu_pkg::reg_addr_t raddr1,
    input  wire cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t          rdata1,
    output cpu_pkg::word_t          rdata2
);
    import cpu_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t   instr,
    output cpu_pkg::inst_class_e  cls,
    output cpu_pkg::reg_addr_t    rs1,
    output cpu_pkg::reg_addr_t    rs2,
    output cpu_pkg::reg_addr_t    rd,
    output cpu_pkg::word_t        imm,
    output cpu_pkg::alu_op_e      alu_op,
    output logic                  use_imm,
    output logic [2:0]            funct3
);
    import cpu_pkg::*;

    logic [6:0] opc;
    logic       alt;

    function automatic alu_op_e op_from_funct(input logic [2:0] f3, input logic f7b5);
        case (f3)
            3'b000:  return f7b5 ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return f7b5 ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    assign opc    = instr[6:0];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    // addi has no sub form, only shifts look at bit 30 for OP_IMM
    assign alt = instr[30] && (opc == OPC_OP || instr[14:12] == 3'b101);

    always_comb begin
        cls     = CLS_ILLEGAL;
        imm     = '0;
        use_imm = 1'b0;
        alu_op  = ADD;
        case (opc)
            OPC_LUI: begin
                cls = CLS_LUI;
                imm = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                cls = CLS_JAL;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                cls     = CLS_JALR;
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
            end
            OPC_BRANCH: begin
                cls = CLS_BRANCH;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_LOAD: begin
                cls     = CLS_LOAD;
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
            end
            OPC_STORE: begin
                cls     = CLS_STORE;
                imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm = 1'b1;
            end
            OPC_OP_IMM: begin
                cls     = CLS_ALU;
                imm     = {{20{instr[31]}}, instr[31:20]};
                use_imm = 1'b1;
                alu_op  = op_from_funct(instr[14:12], alt);
            end
            OPC_OP: begin
                cls    = CLS_ALU;
                alu_op = op_from_funct(instr[14:12], alt);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_e op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire [2:0]             funct3,
    output cpu_pkg::word_t        result,
    output logic                  branch_taken
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // branch compare, funct3 as in the B-type encoding
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (a == b);
            3'b001:  branch_taken = (a != b);
            3'b100:  branch_taken = ($signed(a) < $signed(b));
            3'b101:  branch_taken = ($signed(a) >= $signed(b));
            3'b110:  branch_taken = (a < b);
            3'b111:  branch_taken = (a >= b);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit #(
    parameter int MEM_AW = 10
) (
    input  wire                 clk,
    input  wire                 native_rstn,
    input  wire                 fetch_req,
    output logic                fetch_ack,
    input  wire cpu_pkg::word_t pc,
    output cpu_pkg::word_t      instr,
    output logic                if_req,
    input  wire                 if_ack,
    output logic [MEM_AW-1:0]   if_addr,
    input  wire cpu_pkg::word_t arb_rdata
);

    logic start;
    logic done;

    // both handshakes must be back to zero before a new fetch
    assign start = fetch_req && !fetch_ack && !if_req && !if_ack;
    assign done  = if_req && if_ack;

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            if_req    <= 1'b0;
            fetch_ack <= 1'b0;
        end else begin
            if (start) begin
                if_req <= 1'b1;
            end
            if (done) begin
                if_req    <= 1'b0;
                fetch_ack <= 1'b1;
            end
            if (fetch_ack && !fetch_req) begin
                fetch_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if_addr <= pc[MEM_AW+1:2];
        end
        if (done) begin
            instr <= arb_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_store_unit #(
    parameter int MEM_AW = 10
) (
    input  wire                 clk,
    input  wire                 native_rstn,
    input  wire                 ls_req,
    output logic                ls_ack,
    input  wire                 ls_we,
    input  wire cpu_pkg::word_t ls_addr,
    input  wire cpu_pkg::word_t ls_wdata,
    output cpu_pkg::word_t      ls_rdata,
    output logic                dm_req,
    input  wire                 dm_ack,
    output logic                dm_we,
    output logic [MEM_AW-1:0]   dm_addr,
    output cpu_pkg::word_t      dm_wdata,
    input  wire cpu_pkg::word_t arb_rdata
);

    logic start;
    logic done;

    assign start = ls_req && !ls_ack && !dm_req && !dm_ack;
    assign done  = dm_req && dm_ack;

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            dm_req <= 1'b0;
            ls_ack <= 1'b0;
        end else begin
            if (start) begin
                dm_req <= 1'b1;
            end
            if (done) begin
                dm_req <= 1'b0;
                ls_ack <= 1'b1;
            end
            if (ls_ack && !ls_req) begin
                ls_ack <= 1'b0;
            end
        end
    end

    // byte address to word address
    always_ff @(posedge clk) begin
        if (start) begin
            dm_we    <= ls_we;
            dm_addr  <= ls_addr[MEM_AW+1:2];
            dm_wdata <= ls_wdata;
        end
        if (done && !dm_we) begin
            ls_rdata <= arb_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter #(
    parameter int MEM_AW = 10
) (
    input  wire                 clk,
    input  wire                 native_rstn,
    input  wire                 if_req,
    output logic                if_ack,
    input  wire [MEM_AW-1:0]    if_addr,
    input  wire                 dm_req,
    output logic                dm_ack,
    input  wire                 dm_we,
    input  wire [MEM_AW-1:0]    dm_addr,
    input  wire cpu_pkg::word_t dm_wdata,
    output cpu_pkg::word_t      arb_rdata,
    output logic [MEM_AW-1:0]   mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    output logic                mem_we,
    output logic                mem_re,
    input  wire cpu_pkg::word_t mem_rdata
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_STROBE, ARB_READ, ARB_ACK} arb_state_e;

    arb_state_e state;
    logic       gnt_dm;

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            state  <= ARB_IDLE;
            gnt_dm <= 1'b0;
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            if_ack <= 1'b0;
            dm_ack <= 1'b0;
        end else begin
            // strobes last one cycle
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (dm_req) begin
                        gnt_dm <= 1'b1;
                        mem_we <= dm_we;
                        mem_re <= !dm_we;
                        state  <= ARB_STROBE;
                    end else if (if_req) begin
                        gnt_dm <= 1'b0;
                        mem_re <= 1'b1;
                        state  <= ARB_STROBE;
                    end
                end
                ARB_STROBE: begin
                    if (mem_we) begin
                        dm_ack <= 1'b1;
                        state  <= ARB_ACK;
                    end else begin
                        state <= ARB_READ;
                    end
                end
                ARB_READ: begin
                    dm_ack <= gnt_dm;
                    if_ack <= !gnt_dm;
                    state  <= ARB_ACK;
                end
                ARB_ACK: begin
                    if (gnt_dm ? !dm_req : !if_req) begin
                        dm_ack <= 1'b0;
                        if_ack <= 1'b0;
                        state  <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            mem_addr  <= dm_req ? dm_addr : if_addr;
            mem_wdata <= dm_wdata;
        end
        // read data arrives one cycle after the strobe
        if (state == ARB_READ) begin
            arb_rdata <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter int MEM_AW = 10
) (
    input  wire                 clk,
    input  wire                 native_rstn,
    output logic [MEM_AW-1:0]   mem_addr,
    output cpu_pkg::word_t      mem_wdata,
    output logic                mem_we,
    output logic                mem_re,
    input  wire cpu_pkg::word_t mem_rdata,
    output logic                halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXECUTE,
        S_MEM_WAIT,
        S_WRITE,
        S_HALT
    } state_e;

    state_e      state;
    word_t       pc;
    word_t       pc_plus4;
    word_t       next_pc;
    word_t       a_q;
    word_t       b_q;
    word_t       wb_data;
    logic        wb_en;

    logic        fetch_req;
    logic        fetch_ack;
    word_t       instr;
    logic        ls_req;
    logic        ls_ack;
    logic        ls_we;
    word_t       ls_addr;
    word_t       ls_wdata;
    word_t       ls_rdata;

    logic              if_req;
    logic              if_ack;
    logic [MEM_AW-1:0] if_addr;
    logic              dm_req;
    logic              dm_ack;
    logic              dm_we;
    logic [MEM_AW-1:0] dm_addr;
    word_t             dm_wdata;
    word_t             arb_rdata;

    inst_class_e cls;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    word_t       imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic [2:0]  funct3;
    word_t       rdata1;
    word_t       rdata2;
    word_t       alu_result;
    logic        branch_taken;

    assign pc_plus4 = pc + word_t'(4);

    reg_file u_reg_file (
        .clk(clk), .native_rstn(native_rstn),
        .we(state == S_WRITE && wb_en), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2)
    );

    // decodes the word held by the fetch unit
    decoder u_decoder (
        .instr(instr), .cls(cls), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .use_imm(use_imm), .funct3(funct3)
    );

    alu u_alu (
        .op(alu_op), .a(a_q), .b(b_q), .funct3(funct3),
        .result(alu_result), .branch_taken(branch_taken)
    );

    fetch_unit #(.MEM_AW(MEM_AW)) u_fetch (
        .clk(clk), .native_rstn(native_rstn),
        .fetch_req(fetch_req), .fetch_ack(fetch_ack), .pc(pc), .instr(instr),
        .if_req(if_req), .if_ack(if_ack), .if_addr(if_addr), .arb_rdata(arb_rdata)
    );

    load_store_unit #(.MEM_AW(MEM_AW)) u_lsu (
        .clk(clk), .native_rstn(native_rstn),
        .ls_req(ls_req), .ls_ack(ls_ack), .ls_we(ls_we), .ls_addr(ls_addr),
        .ls_wdata(ls_wdata), .ls_rdata(ls_rdata),
        .dm_req(dm_req), .dm_ack(dm_ack), .dm_we(dm_we), .dm_addr(dm_addr),
        .dm_wdata(dm_wdata), .arb_rdata(arb_rdata)
    );

    mem_arbiter #(.MEM_AW(MEM_AW)) u_arb (
        .clk(clk), .native_rstn(native_rstn),
        .if_req(if_req), .if_ack(if_ack), .if_addr(if_addr),
        .dm_req(dm_req), .dm_ack(dm_ack), .dm_we(dm_we), .dm_addr(dm_addr),
        .dm_wdata(dm_wdata), .arb_rdata(arb_rdata),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_re(mem_re),
        .mem_rdata(mem_rdata)
    );

    // sequencer
    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            state     <= S_FETCH;
            pc        <= '0;
            fetch_req <= 1'b0;
            ls_req    <= 1'b0;
            halted    <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (!fetch_ack) begin
                        fetch_req <= 1'b1;
                        state     <= S_FETCH_WAIT;
                    end
                end
                S_FETCH_WAIT: begin
                    if (fetch_ack) begin
                        fetch_req <= 1'b0;
                        state     <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    if (cls == CLS_ILLEGAL) begin
                        halted <= 1'b1;
                        state  <= S_HALT;
                    end else begin
                        state <= S_EXECUTE;
                    end
                end
                S_EXECUTE: begin
                    if (cls == CLS_LOAD || cls == CLS_STORE) begin
                        if (!ls_ack) begin
                            ls_req <= 1'b1;
                            state  <= S_MEM_WAIT;
                        end
                    end else begin
                        state <= S_WRITE;
                    end
                end
                S_MEM_WAIT: begin
                    if (ls_ack) begin
                        ls_req <= 1'b0;
                        state  <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    pc    <= {next_pc[XLEN-1:2], 2'b00};
                    state <= S_FETCH;
                end
                default: ;
            endcase
        end
    end

    // operands, results and the memory request payload
    always_ff @(posedge clk) begin
        case (state)
            S_DECODE: begin
                a_q <= rdata1;
                b_q <= use_imm ? imm : rdata2;
            end
            S_EXECUTE: begin
                next_pc  <= pc_plus4;
                wb_en    <= 1'b1;
                wb_data  <= alu_result;
                ls_we    <= (cls == CLS_STORE);
                ls_addr  <= alu_result;
                ls_wdata <= rdata2;
                case (cls)
                    CLS_LUI: wb_data <= imm;
                    CLS_JAL: begin
                        wb_data <= pc_plus4;
                        next_pc <= pc + imm;
                    end
                    CLS_JALR: begin
                        wb_data <= pc_plus4;
                        next_pc <= {alu_result[XLEN-1:1], 1'b0};
                    end
                    CLS_BRANCH: begin
                        wb_en <= 1'b0;
                        if (branch_taken) begin
                            next_pc <= pc + imm;
                        end
                    end
                    CLS_STORE: wb_en <= 1'b0;
                    default: ;
                endcase
            end
            S_MEM_WAIT: begin
                if (ls_ack) begin
                    wb_data <= ls_rdata;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int QUIET_CYCLES  = 50;
    localparam int CYC_PER_INSTR = 20;
    localparam int NUM_TESTS     = 5;
    localparam int HALT_TEST     = 4;

    logic       clk = 1'b0;
    logic       native_rstn;
    word_t      mem_rdata = '0;
    logic [9:0] mem_addr;
    word_t      mem_wdata;
    logic       mem_we;
    logic       mem_re;
    logic       halted;

    word_t       mem   [0:1023];
    word_t       image [0:1023];
    logic [9:0]  pc_w;
    logic [11:0] st_ptr;
    integer      seed;
    int          limit_ns;
    int          errors = 0;
    int          tests_failed = 0;
    int          test_err  [NUM_TESTS] = '{default: 0};
    int          remaining [NUM_TESTS] = '{default: 0};
    string       test_name [NUM_TESTS] = '{"alu", "lui_jal_jalr", "branch", "load_store",
                                           "x0_halt"};
    logic [9:0]  exp_addr [$];
    word_t       exp_data [$];
    int          exp_test [$];

    cpu_top #(.MEM_AW(10)) uut (
        .clk(clk), .native_rstn(native_rstn),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_re(mem_re),
        .mem_rdata(mem_rdata), .halted(halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // program image is copied in while reset is held
    always @(posedge clk) begin
        if (!native_rstn) begin
            mem <= image;
        end else if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // one-cycle read latency
    always @(negedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem[mem_addr];
        end
    end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!native_rstn)
        halted |-> !(mem_re || mem_we))
        else begin
            errors++;
            test_err[HALT_TEST]++;
            $display("memory access at %0t after the processor halted", $time);
        end

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // RV32I arithmetic rules
    function automatic word_t alu_expected(input logic [2:0] f3, input logic alt,
                                           input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_expected(input logic [2:0] f3, input word_t a,
                                             input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t here_addr();
        return {20'b0, pc_w, 2'b00};
    endfunction

    task automatic emit(input word_t w);
        image[pc_w] = w;
        pc_w++;
    endtask

    task automatic load_const(input reg_addr_t rd, input word_t v);
        word_t upper;
        upper = v + 32'h800;
        emit(u_type(upper[31:12], rd));
        emit(i_type(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    task automatic push_expect(input word_t value, input int t);
        exp_addr.push_back(st_ptr[11:2]);
        exp_data.push_back(value);
        exp_test.push_back(t);
        remaining[t]++;
        st_ptr = st_ptr + 12'd4;
    endtask

    task automatic store_expect(input reg_addr_t rs2, input word_t value, input int t);
        emit(s_type(st_ptr, rs2, 5'd0));
        push_expect(value, t);
    endtask

    // never executed and aimed at an address no test expects
    task automatic skipped_store();
        emit(s_type(12'h7fc, 5'd1, 5'd0));
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_addr_t r1, input reg_addr_t r2,
                               input word_t va, input word_t vb);
        emit(b_type(13'd12, r2, r1, f3));
        emit(s_type(st_ptr, 5'd12, 5'd0));
        emit(j_type(21'd8, 5'd0));
        emit(s_type(st_ptr, 5'd13, 5'd0));
        push_expect(branch_expected(f3, va, vb) ? 32'h0000_f0f0 : 32'h0000_0f0f, 2);
    endtask

    task automatic build_program();
        word_t       a;
        word_t       b;
        word_t       v;
        word_t       link;
        word_t       tgt;
        logic [11:0] imm;
        logic [19:0] imm20;
        logic [2:0]  br_f3 [6];
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < 1024; i++) begin
            image[i] = {i[9:0], ~i[9:0], 12'h0a5};
        end
        pc_w = '0;
        st_ptr = 12'h400;
        a = $random(seed);
        b = $random(seed);
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f = 0; f < 8; f++) begin
            emit(r_type(7'b0, 5'd2, 5'd1, 3'(f), 5'd3));
            store_expect(5'd3, alu_expected(3'(f), 1'b0, a, b), 0);
        end
        emit(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3));
        store_expect(5'd3, alu_expected(3'b000, 1'b1, a, b), 0);
        emit(r_type(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd3));
        store_expect(5'd3, alu_expected(3'b101, 1'b1, a, b), 0);
        for (int f = 0; f < 9; f++) begin
            imm = 12'($random(seed));
            if (f == 1 || f == 5) begin
                imm = {7'b0, imm[4:0]};
            end else if (f == 8) begin
                imm = {7'b0100000, imm[4:0]};
            end
            emit(i_type(imm, 5'd1, (f == 8) ? 3'b101 : 3'(f), 5'd4, OPC_OP_IMM));
            store_expect(5'd4, alu_expected((f == 8) ? 3'b101 : 3'(f), f == 8, a,
                                            {{20{imm[11]}}, imm}), 0);
        end
        imm20 = 20'($random(seed));
        emit(u_type(imm20, 5'd5));
        store_expect(5'd5, {imm20, 12'b0}, 1);
        link = here_addr() + 32'd4;
        emit(j_type(21'd12, 5'd6));
        skipped_store();
        skipped_store();
        store_expect(5'd6, link, 1);
        // base plus an odd offset lands on the word at tgt
        tgt = here_addr() + 32'd16;
        load_const(5'd8, tgt - 32'd8);
        emit(i_type(12'd9, 5'd8, 3'b000, 5'd9, OPC_JALR));
        skipped_store();
        store_expect(5'd9, tgt - 32'd4, 1);
        a = $random(seed);
        b = $random(seed);
        if (a == b) begin
            b = ~a;
        end
        load_const(5'd10, a);
        load_const(5'd11, b);
        load_const(5'd12, 32'h0000_0f0f);
        load_const(5'd13, 32'h0000_f0f0);
        for (int k = 0; k < 6; k++) begin
            branch_case(br_f3[k], 5'd10, 5'd11, a, b);
            branch_case(br_f3[k], 5'd11, 5'd10, b, a);
            branch_case(br_f3[k], 5'd10, 5'd10, a, a);
        end
        v = $random(seed);
        load_const(5'd15, v);
        imm = st_ptr;
        store_expect(5'd15, v, 3);
        emit(i_type(imm, 5'd0, 3'b010, 5'd16, OPC_LOAD));
        store_expect(5'd16, v, 3);
        emit(i_type(12'h5a5, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));
        store_expect(5'd0, '0, HALT_TEST);
        emit(32'h0000_007f);
    endtask

    task automatic report_test(input int t);
        if (test_err[t] != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", t, test_name[t],
                 (test_err[t] == 0) ? "ok" : "mismatch", test_err[t]);
    endtask

    task automatic check_store();
        int         t;
        logic [9:0] ea;
        word_t      ed;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("store to word %0d at %0t when no store was expected", mem_addr, $time);
        end else begin
            t = exp_test.pop_front();
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            assert (mem_addr == ea) else begin
                errors++;
                test_err[t]++;
                $display("[FAIL] %0t mem_addr: got %h, expected %h", $time, mem_addr, ea);
            end
            assert (mem_wdata == ed) else begin
                errors++;
                test_err[t]++;
                $display("[FAIL] %0t mem_wdata: got %h, expected %h", $time, mem_wdata, ed);
            end
            remaining[t]--;
            if (remaining[t] == 0 && t != HALT_TEST) begin
                report_test(t);
            end
        end
    endtask

    always @(negedge clk) begin
        if (native_rstn && mem_we) begin
            check_store();
        end
    end

    initial begin
        native_rstn = 1'b0;
        seed = 32'hfb53;
        build_program();
        limit_ns = (int'(pc_w) * CYC_PER_INSTR * 2 + RESET_CYCLES + QUIET_CYCLES) * CLK_PERIOD;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        native_rstn = 1'b1;
        wait (halted == 1'b1);
        repeat (QUIET_CYCLES) @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (remaining[t] != 0) begin
                errors++;
                test_err[t]++;
                $display("test %0d %s: %0d expected stores never appeared", t, test_name[t],
                         remaining[t]);
                if (t != HALT_TEST) begin
                    report_test(t);
                end
            end
        end
        report_test(HALT_TEST);
        $display("tests: %0d run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // limit follows from the program length once it is built
    initial begin
        #1;
        #(limit_ns);
        $display("timeout: the processor did not halt within %0d ns", limit_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
cpu_pkg.sv
reg_file.sv
decoder.sv
alu.sv
fetch_unit.sv
load_store_unit.sv
mem_arbiter.sv
cpu_top.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f all.f -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
